//--- dv/periph_subsys_tb.sv
/*
 * Testbench for the peripheral subsystem. It drives the AHB-lite port on the falling edge.
 * It assumes the default tick divider and UART bit time from the constants header.
 */
`timescale 1ns/100ps
`include "periph_consts.svh"

module periph_subsys_tb;
	import periph_pkg::*;

	localparam logic [15:0] TMR_CTRL = `TIMER_BASE | `TIMER_CTRL_OFS;
	localparam logic [15:0] TMR_MTIME = `TIMER_BASE | `TIMER_MTIME_OFS;
	localparam logic [15:0] TMR_CMP = `TIMER_BASE | `TIMER_MTIMECMP_OFS;
	localparam logic [15:0] TMR_CMPH = `TIMER_BASE | `TIMER_MTIMECMPH_OFS;
	localparam logic [15:0] UART_TXD = `UART_BASE | `UART_TXDATA_OFS;
	localparam logic [15:0] UART_STAT = `UART_BASE | `UART_STATUS_OFS;
	localparam int UART_FRAMES = 3;
	// sum of uart frames, timer waits and bus transfers plus margin
	localparam int TIMEOUT_CYCLES = 4 * 10 * `UART_CLKS_PER_BIT +
		4 * 64 * `PERIPH_CLK_MHZ + 200 * 8 + 500;

	logic        clk;
	logic        rst_n;
	ahbl_req_t   ahb_req;
	logic [31:0] hwdata;
	logic        hready;
	logic        hready_resp;
	logic        hresp;
	logic [31:0] hrdata;
	logic        dbg_halt;
	logic        timer_irq;
	logic        uart_tx;
	int unsigned cycle;

	assign hready = hready_resp;

	periph_subsys u_periph_subsys (
		.clk         (clk),
		.rst_n       (rst_n),
		.ahb_req     (ahb_req),
		.hwdata      (hwdata),
		.hready      (hready),
		.hready_resp (hready_resp),
		.hresp       (hresp),
		.hrdata      (hrdata),
		.dbg_halt    (dbg_halt),
		.timer_irq   (timer_irq),
		.uart_tx     (uart_tx)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// ----------------------------------------
	// failure reporting

	task automatic stop_with_failure();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		stop_with_failure();
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
		stop_with_failure();
	endtask

	task automatic expect_eq(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		assert (act == exp) else report_mismatch(name, exp, act);
	endtask

	// error response lasts two cycles with hready_resp low only in the first
	err_resp_second: assert property (@(posedge clk) disable iff (!rst_n)
		(hresp && !hready_resp) |=> (hresp && hready_resp))
		else report_mismatch("err_resp_second", 2'b11,
			{$sampled(hresp), $sampled(hready_resp)});
	err_resp_first: assert property (@(posedge clk) disable iff (!rst_n)
		(hresp && hready_resp) |-> $past(hresp && !hready_resp))
		else report_failure("error response ended without its first cycle");

	// ----------------------------------------
	// AHB master

	task automatic bus_xfer(input logic write, input logic [15:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		waits = 0;
		@(negedge clk);
		ahb_req.haddr  = {16'h0, addr};
		ahb_req.hwrite = write;
		ahb_req.htrans = HTRANS_NONSEQ;
		ahb_req.hsize  = 3'b010;
		@(negedge clk);
		// data phase
		ahb_req.htrans = HTRANS_IDLE;
		hwdata = write ? wdata : 32'h0;
		while (!hready_resp) begin
			waits++;
			@(negedge clk);
		end
		assert (waits >= 2) else report_mismatch("bus_wait_states", 2, waits);
		rdata = hrdata;
		err   = hresp;
	endtask

	task automatic ahb_write(input logic [15:0] addr, input logic [31:0] data,
		output logic err);
		logic [31:0] unused;
		bus_xfer(1'b1, addr, data, unused, err);
	endtask

	task automatic ahb_read(input logic [15:0] addr, output logic [31:0] data,
		output logic err);
		bus_xfer(1'b0, addr, 32'h0, data, err);
	endtask

	task automatic write_ok(input string name, input logic [15:0] addr,
		input logic [31:0] data);
		logic err;
		ahb_write(addr, data, err);
		expect_eq(name, 0, err);
	endtask

	task automatic read_check(input string name, input logic [15:0] addr,
		input logic [31:0] exp);
		logic [31:0] data;
		logic        err;
		ahb_read(addr, data, err);
		expect_eq({name, "_resp"}, 0, err);
		expect_eq(name, exp, data);
	endtask

	// ----------------------------------------
	// tests

	task automatic read_reset_values();
		expect_eq("reset_hready_resp", 1, hready_resp);
		expect_eq("reset_hresp", 0, hresp);
		expect_eq("reset_timer_irq", 0, timer_irq);
		expect_eq("reset_uart_tx", 1, uart_tx);
		read_check("reset_ctrl", TMR_CTRL, 32'h0);
		read_check("reset_mtime", TMR_MTIME, 32'h0);
		read_check("reset_mtimecmp", TMR_CMP, 32'hffff_ffff);
		read_check("reset_mtimecmph", TMR_CMPH, 32'hffff_ffff);
		read_check("reset_uart_status", UART_STAT, 32'h0);
	endtask

	task automatic count_timer_ticks();
		logic [31:0] lo;
		logic [31:0] hi;
		logic [31:0] first;
		logic [31:0] prev;
		logic [31:0] cur;
		logic        err;
		lo = $urandom;
		hi = $urandom;
		write_ok("mtimecmp_write", TMR_CMP, lo);
		write_ok("mtimecmph_write", TMR_CMPH, hi);
		read_check("mtimecmp_readback", TMR_CMP, lo);
		read_check("mtimecmph_readback", TMR_CMPH, hi);
		write_ok("mtimecmph_park", TMR_CMPH, 32'hffff_ffff);
		write_ok("ctrl_enable", TMR_CTRL, 32'h1);
		read_check("ctrl_readback", TMR_CTRL, 32'h1);
		ahb_read(TMR_MTIME, first, err);
		prev = first;
		cur  = first;
		while (cur == first) begin
			ahb_read(TMR_MTIME, cur, err);
			assert (cur >= prev) else report_mismatch("mtime_monotonic", prev, cur);
			prev = cur;
		end
		// frozen while halted
		dbg_halt = 1'b1;
		ahb_read(TMR_MTIME, first, err);
		repeat (10 * `PERIPH_CLK_MHZ) @(negedge clk);
		ahb_read(TMR_MTIME, cur, err);
		expect_eq("mtime_halted", first, cur);
		dbg_halt = 1'b0;
	endtask

	task automatic raise_timer_irq();
		logic [31:0] now;
		logic [31:0] cur;
		logic [31:0] cmp;
		int unsigned off;
		int unsigned t0;
		int unsigned limit;
		logic        err;
		write_ok("irq_cmph_park", TMR_CMPH, 32'hffff_ffff);
		ahb_read(TMR_MTIME, now, err);
		t0    = cycle;
		off   = $urandom_range(20, 1);
		cmp   = now + off;
		limit = (off + 2) * `PERIPH_CLK_MHZ;
		write_ok("irq_cmp_write", TMR_CMP, cmp);
		write_ok("irq_cmph_write", TMR_CMPH, 32'h0);
		do begin
			ahb_read(TMR_MTIME, cur, err);
			// mtime may have ticked once since the read
			if (cur + 1 < cmp) begin
				assert (!timer_irq) else report_mismatch("irq_early", 0, timer_irq);
			end
		end while (!timer_irq);
		assert (cycle - t0 <= limit) else report_mismatch("irq_deadline", limit, cycle - t0);
		write_ok("irq_cmph_clear", TMR_CMPH, 32'hffff_ffff);
		expect_eq("irq_cleared", 0, timer_irq);
	endtask

	task automatic capture_frame(input logic [7:0] data);
		logic exp_bit;
		@(negedge uart_tx);
		repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);
		for (int i = 0; i < 10; i++) begin
			// start bit low, data LSB first, stop bit high
			if (i == 0) begin
				exp_bit = 1'b0;
			end else if (i == 9) begin
				exp_bit = 1'b1;
			end else begin
				exp_bit = data[i-1];
			end
			assert (uart_tx == exp_bit)
				else report_mismatch($sformatf("uart_bit%0d", i), exp_bit, uart_tx);
			if (i < 9) begin
				repeat (`UART_CLKS_PER_BIT) @(negedge clk);
			end
		end
		// past the end of the stop bit
		repeat (`UART_CLKS_PER_BIT / 2 + 1) @(negedge clk);
	endtask

	task automatic send_uart_frame(input logic reject);
		logic [7:0] data;
		logic [7:0] other;
		logic       err;
		data  = 8'($urandom_range(255, 0));
		other = ~data;
		fork
			capture_frame(data);
			begin
				write_ok("uart_txdata", UART_TXD, {24'h0, data});
				read_check("uart_busy", UART_STAT, 32'h1);
				if (reject) begin
					ahb_write(UART_TXD, {24'h0, other}, err);
					expect_eq("uart_write_while_busy", 1, err);
				end
			end
		join
		read_check("uart_idle", UART_STAT, 32'h0);
	endtask

	task automatic access_unmapped();
		logic [31:0] data;
		logic        err;
		ahb_write(16'h8000, $urandom, err);
		expect_eq("unmapped_8000_write", 1, err);
		ahb_read(16'h8000, data, err);
		expect_eq("unmapped_8000_read", 1, err);
		ahb_read(16'hc000, data, err);
		expect_eq("unmapped_c000_read", 1, err);
		ahb_write(16'hc000, $urandom, err);
		expect_eq("unmapped_c000_write", 1, err);
	endtask

	// ----------------------------------------
	// main sequence and watchdog

	initial begin
		void'($urandom(32'h9f34));
		rst_n    = 1'b0;
		ahb_req  = '0;
		hwdata   = 32'h0;
		dbg_halt = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		read_reset_values();
		count_timer_ticks();
		raise_timer_irq();
		for (int i = 0; i < UART_FRAMES; i++) begin
			send_uart_frame(i == 0);
		end
		access_unmapped();
		$display("STATUS: PASS");
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		report_failure($sformatf("timeout: tests not done after %0d clock cycles",
			TIMEOUT_CYCLES));
	end

endmodule

//--- filelist.f
+incdir+hdl
hdl/periph_pkg.sv
hdl/ahbl_to_apb.sv
hdl/apb_splitter.sv
hdl/riscv_timer.sv
hdl/uart_tx.sv
hdl/periph_subsys.sv
dv/periph_subsys_tb.sv

//--- hdl/ahbl_to_apb.sv
/*
 * AHB-lite slave to APB requester. One transfer at a time, every transfer
 * costs at least a setup and an access cycle. Only haddr[15:0] reaches APB,
 * hsize is ignored and all accesses are treated as 32-bit.
 */
`timescale 1ns/100ps

module ahbl_to_apb (
	input  logic                  clk,
	input  logic                  rst_n,

	input  periph_pkg::ahbl_req_t ahb_req,
	input  logic [31:0]           hwdata,
	input  logic                  hready,
	output logic                  hready_resp,
	output logic                  hresp,
	output logic [31:0]           hrdata,

	output periph_pkg::apb_req_t  apb_req,
	input  periph_pkg::apb_rsp_t  apb_rsp
);
	import periph_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS,
		ST_ERR1,
		ST_ERR2
	} state_t;

	state_t      state;
	state_t      state_nxt;
	logic [15:0] paddr_q;
	logic        pwrite_q;
	logic        start;
	logic        done;

	// new address phase, only while the previous data phase is ending
	assign start = hready && hready_resp &&
		(ahb_req.htrans == HTRANS_NONSEQ || ahb_req.htrans == HTRANS_SEQ);

	assign done = (state == ST_ACCESS) && apb_rsp.pready;

	// ----------------------------------------
	// state machine

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE, ST_ERR2: begin
				state_nxt = start ? ST_SETUP : ST_IDLE;
			end
			ST_SETUP: begin
				state_nxt = ST_ACCESS;
			end
			ST_ACCESS: begin
				if (apb_rsp.pready) begin
					state_nxt = apb_rsp.pslverr ? ST_ERR1 : ST_IDLE;
				end
			end
			ST_ERR1: begin
				state_nxt = ST_ERR2;
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// ----------------------------------------
	// address and read data

	always_ff @(posedge clk) begin
		if (start) begin
			paddr_q  <= ahb_req.haddr[15:0];
			pwrite_q <= ahb_req.hwrite;
		end
		if (done && !pwrite_q) begin
			hrdata <= apb_rsp.prdata;
		end
	end

	// two-cycle error response, hready_resp low only in the first
	assign hready_resp = (state == ST_IDLE) || (state == ST_ERR2);
	assign hresp       = (state == ST_ERR1) || (state == ST_ERR2);

	// hwdata is held by the master for the whole data phase
	always_comb begin
		apb_req.psel    = (state == ST_SETUP) || (state == ST_ACCESS);
		apb_req.penable = (state == ST_ACCESS);
		apb_req.pwrite  = pwrite_q;
		apb_req.paddr   = paddr_q;
		apb_req.pwdata  = hwdata;
	end

endmodule

//--- hdl/apb_splitter.sv
/*
 * Combinational APB address decode for the timer and the UART.
 * Unmapped addresses complete at once with pslverr.
 */
`timescale 1ns/100ps
`include "periph_consts.svh"

module apb_splitter (
	input  periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,

	output periph_pkg::apb_req_t timer_req,
	input  periph_pkg::apb_rsp_t timer_rsp,

	output periph_pkg::apb_req_t uart_req,
	input  periph_pkg::apb_rsp_t uart_rsp
);
	logic timer_hit;
	logic uart_hit;

	// top two address bits pick the device
	assign timer_hit = (apb_req.paddr & `APB_DEV_MASK) == `TIMER_BASE;
	assign uart_hit  = (apb_req.paddr & `APB_DEV_MASK) == `UART_BASE;

	// ----------------------------------------
	// request fan-out

	always_comb begin
		timer_req      = apb_req;
		timer_req.psel = apb_req.psel && timer_hit;

		uart_req      = apb_req;
		uart_req.psel = apb_req.psel && uart_hit;
	end

	// ----------------------------------------
	// response mux

	always_comb begin
		if (timer_hit) begin
			apb_rsp = timer_rsp;
		end else if (uart_hit) begin
			apb_rsp = uart_rsp;
		end else begin
			// nobody home
			apb_rsp.prdata  = 32'h0;
			apb_rsp.pready  = 1'b1;
			apb_rsp.pslverr = 1'b1;
		end
	end

endmodule

//--- hdl/periph_consts.svh
/*
 * Address map, register offsets and timing constants of the peripheral bus.
 * PERIPH_CLK_MHZ is set low for simulation and must match the real clock on silicon.
 */
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// ----------------------------------------
// timing

// clocks per microsecond tick
`define PERIPH_CLK_MHZ 5
// clocks per serial bit
`define UART_CLKS_PER_BIT 8

// ----------------------------------------
// APB address map

`define APB_DEV_MASK 16'hc000
`define TIMER_BASE 16'h0000
`define UART_BASE 16'h4000

// timer registers, bit 0 of CTRL is the enable
`define TIMER_CTRL_OFS 16'h0000
`define TIMER_MTIME_OFS 16'h0008
`define TIMER_MTIMEH_OFS 16'h000c
`define TIMER_MTIMECMP_OFS 16'h0010
`define TIMER_MTIMECMPH_OFS 16'h0014

// uart registers, bit 0 of STATUS is busy
`define UART_TXDATA_OFS 16'h0000
`define UART_STATUS_OFS 16'h0004

`endif

//--- hdl/periph_pkg.sv
/*
 * Bus types shared by the bridge, the splitter and the peripherals.
 * APB addresses are 16 bits wide, so each device sees a 16 kB window.
 */
package periph_pkg;

	// AHB-lite transfer types
	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_BUSY   = 2'b01,
		HTRANS_NONSEQ = 2'b10,
		HTRANS_SEQ    = 2'b11
	} htrans_t;

	// address phase of an AHB-lite transfer
	typedef struct packed {
		logic [31:0] haddr;
		logic        hwrite;
		htrans_t     htrans;
		logic [2:0]  hsize;
	} ahbl_req_t;

	// ----------------------------------------
	// APB

	// requester to completer
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [15:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	// completer to requester
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

//--- hdl/periph_subsys.sv
/*
 * Peripheral subsystem behind one AHB-lite slave port.
 * Timer at 0x0000 and UART at 0x4000 of the 16-bit APB space.
 */
`timescale 1ns/100ps

module periph_subsys (
	input  logic                  clk,
	input  logic                  rst_n,

	input  periph_pkg::ahbl_req_t ahb_req,
	input  logic [31:0]           hwdata,
	input  logic                  hready,
	output logic                  hready_resp,
	output logic                  hresp,
	output logic [31:0]           hrdata,

	input  logic                  dbg_halt,
	output logic                  timer_irq,
	output logic                  uart_tx
);
	import periph_pkg::*;

	apb_req_t bridge_req;
	apb_rsp_t bridge_rsp;
	apb_req_t timer_req;
	apb_rsp_t timer_rsp;
	apb_req_t uart_req;
	apb_rsp_t uart_rsp;

	// ----------------------------------------
	// bus path

	ahbl_to_apb u_bridge (
		.clk         (clk),
		.rst_n       (rst_n),
		.ahb_req     (ahb_req),
		.hwdata      (hwdata),
		.hready      (hready),
		.hready_resp (hready_resp),
		.hresp       (hresp),
		.hrdata      (hrdata),
		.apb_req     (bridge_req),
		.apb_rsp     (bridge_rsp)
	);

	apb_splitter u_splitter (
		.apb_req   (bridge_req),
		.apb_rsp   (bridge_rsp),
		.timer_req (timer_req),
		.timer_rsp (timer_rsp),
		.uart_req  (uart_req),
		.uart_rsp  (uart_rsp)
	);

	// ----------------------------------------
	// peripherals

	riscv_timer u_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.apb_req   (timer_req),
		.apb_rsp   (timer_rsp),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	uart_tx u_uart (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (uart_req),
		.apb_rsp (uart_rsp),
		.uart_tx (uart_tx)
	);

endmodule

//--- hdl/riscv_timer.sv
/*
 * RISC-V machine timer with its own microsecond tick divider.
 * mtime stops while dbg_halt is high. A 64-bit value is written as two
 * halves, so software must guard against a carry between the writes.
 */
`timescale 1ns/100ps
`include "periph_consts.svh"

module riscv_timer #(
	parameter int TICK_DIV = `PERIPH_CLK_MHZ
) (
	input  logic                 clk,
	input  logic                 rst_n,

	input  periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,

	input  logic                 dbg_halt,
	output logic                 timer_irq
);
	localparam int CTR_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [CTR_W-1:0] tick_ctr;
	logic             tick;
	logic             en;
	logic [63:0]      mtime;
	logic [63:0]      mtimecmp;
	logic [15:0]      ofs;
	logic             wr;

	assign ofs = apb_req.paddr & ~`APB_DEV_MASK;
	assign wr  = apb_req.psel && apb_req.penable && apb_req.pwrite;

	// ----------------------------------------
	// microsecond tick

	assign tick = (tick_ctr == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= CTR_W'(TICK_DIV - 1);
		end else if (tick) begin
			tick_ctr <= CTR_W'(TICK_DIV - 1);
		end else begin
			tick_ctr <= tick_ctr - 1'b1;
		end
	end

	// ----------------------------------------
	// registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en       <= 1'b0;
			mtime    <= 64'h0;
			mtimecmp <= '1;
		end else begin
			if (wr && ofs == `TIMER_CTRL_OFS) begin
				en <= apb_req.pwdata[0];
			end
			// a bus write wins over the increment
			if (wr && ofs == `TIMER_MTIME_OFS) begin
				mtime[31:0] <= apb_req.pwdata;
			end else if (wr && ofs == `TIMER_MTIMEH_OFS) begin
				mtime[63:32] <= apb_req.pwdata;
			end else if (tick && en && !dbg_halt) begin
				mtime <= mtime + 64'd1;
			end
			if (wr && ofs == `TIMER_MTIMECMP_OFS) begin
				mtimecmp[31:0] <= apb_req.pwdata;
			end
			if (wr && ofs == `TIMER_MTIMECMPH_OFS) begin
				mtimecmp[63:32] <= apb_req.pwdata;
			end
		end
	end

	// read mux, holes read as zero
	always_comb begin
		case (ofs)
			`TIMER_CTRL_OFS:      apb_rsp.prdata = {31'h0, en};
			`TIMER_MTIME_OFS:     apb_rsp.prdata = mtime[31:0];
			`TIMER_MTIMEH_OFS:    apb_rsp.prdata = mtime[63:32];
			`TIMER_MTIMECMP_OFS:  apb_rsp.prdata = mtimecmp[31:0];
			`TIMER_MTIMECMPH_OFS: apb_rsp.prdata = mtimecmp[63:32];
			default:              apb_rsp.prdata = 32'h0;
		endcase
		apb_rsp.pready  = 1'b1;
		apb_rsp.pslverr = 1'b0;
	end

	assign timer_irq = en && (mtime >= mtimecmp);

endmodule

//--- hdl/uart_tx.sv
/*
 * Transmit-only UART, 8N1, LSB first, no FIFO.
 * A TXDATA write while a frame is in flight is refused with pslverr.
 */
`timescale 1ns/100ps
`include "periph_consts.svh"

module uart_tx #(
	parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
	input  logic                 clk,
	input  logic                 rst_n,

	input  periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,

	output logic                 uart_tx
);
	localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	// stop, data, start; bit 0 is on the line
	logic [9:0]        shift_q;
	logic [BAUD_W-1:0] baud_ctr;
	logic [3:0]        bit_cnt;
	logic              busy;
	logic [15:0]       ofs;
	logic              tx_wr;

	assign ofs   = apb_req.paddr & ~`APB_DEV_MASK;
	assign tx_wr = apb_req.psel && apb_req.penable && apb_req.pwrite &&
		ofs == `UART_TXDATA_OFS;

	// ----------------------------------------
	// frame shifter

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shift_q  <= '1;
			baud_ctr <= '0;
			bit_cnt  <= 4'd0;
			busy     <= 1'b0;
		end else if (tx_wr && !busy) begin
			shift_q  <= {1'b1, apb_req.pwdata[7:0], 1'b0};
			baud_ctr <= BAUD_W'(CLKS_PER_BIT - 1);
			bit_cnt  <= 4'd0;
			busy     <= 1'b1;
		end else if (busy) begin
			if (baud_ctr == '0) begin
				// end of a bit, idle ones fill from the top
				shift_q  <= {1'b1, shift_q[9:1]};
				baud_ctr <= BAUD_W'(CLKS_PER_BIT - 1);
				bit_cnt  <= bit_cnt + 1'b1;
				if (bit_cnt == 4'd9) begin
					busy <= 1'b0;
				end
			end else begin
				baud_ctr <= baud_ctr - 1'b1;
			end
		end
	end

	assign uart_tx = shift_q[0];

	// ----------------------------------------
	// bus response

	always_comb begin
		apb_rsp.prdata  = (ofs == `UART_STATUS_OFS) ? {31'h0, busy} : 32'h0;
		apb_rsp.pready  = 1'b1;
		apb_rsp.pslverr = tx_wr && busy;
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the peripheral subsystem testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=periph_subsys_sim

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module periph_subsys_tb \
	--Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0
